// ==== hist_pkg.sv ====
`default_nettype none

package hist_pkg;

    localparam int BIN_W   = 4;  // 16 time bins per pixel
    localparam int PIX_W   = 2;  // up to 4 pixels
    localparam int COUNT_W = 8;

    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [PIX_W-1:0]   pix_t;
    typedef logic [COUNT_W-1:0] count_t;

    // hit tagged with its pixel, as seen by the bin table
    typedef struct packed {
        logic valid;
        pix_t pixel;
        bin_t bin;
        logic last;     // closes the frame
    } hist_hit_t;

    typedef struct packed {
        logic   valid;
        pix_t   pixel;
        bin_t   bin;
        logic   last;
        count_t count;  // count after increment
    } hist_update_t;

    typedef struct packed {
        pix_t   pixel;
        bin_t   bin;
        count_t count;
    } hist_peak_t;

endpackage

`default_nettype wire

// ==== hist_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_sequencer #(
    parameter int NUM_PIXELS       = 4,
    parameter int HITS_PER_PIXEL   = 2,
    parameter int PASSES_PER_FRAME = 3
) (
    input  wire logic                clk,
    input  wire logic                combin_res,
    input  wire logic                hit_valid,
    input  wire hist_pkg::bin_t      hit_bin,
    output hist_pkg::hist_hit_t      hit
);

    localparam int IN_W   = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int PASS_W = (PASSES_PER_FRAME > 1) ? $clog2(PASSES_PER_FRAME) : 1;

    logic [IN_W-1:0]   input_count;  // hits seen in current pixel
    hist_pkg::pix_t    pixel_count;
    logic [PASS_W-1:0] pass_count;

    logic input_last;
    logic pixel_last;
    logic pass_last;

    assign input_last = (input_count == IN_W'(HITS_PER_PIXEL - 1));
    assign pixel_last = (pixel_count == hist_pkg::PIX_W'(NUM_PIXELS - 1));
    assign pass_last  = (pass_count == PASS_W'(PASSES_PER_FRAME - 1));

    // tag the incoming hit with the pixel it belongs to
    always_comb begin
        hit.valid = hit_valid;
        hit.pixel = pixel_count;
        hit.bin   = hit_bin;
        hit.last  = hit_valid && input_last && pixel_last && pass_last;
    end

    // nested counters, inner one advances on every hit
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_count <= '0;
            pixel_count <= '0;
            pass_count  <= '0;
        end else if (hit_valid) begin
            if (input_last) begin
                input_count <= '0;
                if (pixel_last) begin
                    pixel_count <= '0;
                    if (pass_last) begin
                        pass_count <= '0;  // frame complete
                    end else begin
                        pass_count <= pass_count + 1'b1;
                    end
                end else begin
                    pixel_count <= pixel_count + 1'b1;
                end
            end else begin
                input_count <= input_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hist_bin_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_bin_ram #(
    parameter int NUM_PIXELS = 4
) (
    input  wire logic                 clk,
    input  wire logic                 combin_res,
    input  wire hist_pkg::hist_hit_t  hit,
    output hist_pkg::hist_update_t    update
);

    localparam int NUM_BINS = 2 ** hist_pkg::BIN_W;

    hist_pkg::count_t bin_table [NUM_PIXELS][NUM_BINS];

    hist_pkg::count_t new_count;  // read-increment result

    logic             upd_valid;
    logic             upd_last;
    hist_pkg::pix_t   upd_pixel;
    hist_pkg::bin_t   upd_bin;
    hist_pkg::count_t upd_count;

    assign new_count = bin_table[hit.pixel][hit.bin] + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                for (int b = 0; b < NUM_BINS; b++) begin
                    bin_table[p][b] <= '0;
                end
            end
        end else if (hit.valid && hit.last) begin
            // frame end wipes every histogram at once
            for (int p = 0; p < NUM_PIXELS; p++) begin
                for (int b = 0; b < NUM_BINS; b++) begin
                    bin_table[p][b] <= '0;
                end
            end
        end else if (hit.valid) begin
            bin_table[hit.pixel][hit.bin] <= new_count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd_valid <= 1'b0;
            upd_last  <= 1'b0;
        end else begin
            upd_valid <= hit.valid;
            upd_last  <= hit.last;
        end
    end

    always_ff @(posedge clk) begin
        upd_pixel <= hit.pixel;
        upd_bin   <= hit.bin;
        upd_count <= new_count;  // also reported for the clearing hit
    end

    always_comb begin
        update.valid = upd_valid;
        update.pixel = upd_pixel;
        update.bin   = upd_bin;
        update.last  = upd_last;
        update.count = upd_count;
    end

endmodule

`default_nettype wire

// ==== hist_peak_finder.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_peak_finder #(
    parameter int NUM_PIXELS = 4
) (
    input  wire logic                    clk,
    input  wire logic                    combin_res,
    input  wire hist_pkg::hist_update_t  update,
    output logic                         peak_valid,
    output hist_pkg::hist_peak_t         peak
);

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t state;
    hist_pkg::pix_t ptr;  // pixel being streamed

    hist_pkg::count_t max_count [NUM_PIXELS];
    hist_pkg::bin_t   max_bin   [NUM_PIXELS];
    hist_pkg::count_t next_count [NUM_PIXELS];
    hist_pkg::bin_t   next_bin   [NUM_PIXELS];
    hist_pkg::count_t snap_count [NUM_PIXELS];
    hist_pkg::bin_t   snap_bin   [NUM_PIXELS];

    logic frame_end;

    assign frame_end = update.valid && update.last;

    // strictly greater only, so ties keep the earlier bin
    always_comb begin
        for (int p = 0; p < NUM_PIXELS; p++) begin
            next_count[p] = max_count[p];
            next_bin[p]   = max_bin[p];
            if (update.valid && update.pixel == hist_pkg::pix_t'(p)
                && update.count > max_count[p]) begin
                next_count[p] = update.count;
                next_bin[p]   = update.bin;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                max_count[p] <= '0;
                max_bin[p]   <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                max_count[p] <= frame_end ? '0 : next_count[p];
                max_bin[p]   <= frame_end ? '0 : next_bin[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            for (int p = 0; p < NUM_PIXELS; p++) begin
                snap_count[p] <= next_count[p];  // includes the final update
                snap_bin[p]   <= next_bin[p];
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= ST_IDLE;
            ptr   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    ptr <= '0;
                    if (frame_end) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (ptr == hist_pkg::pix_t'(NUM_PIXELS - 1)) begin
                        state <= ST_IDLE;
                        ptr   <= '0;
                    end else begin
                        ptr <= ptr + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign peak_valid = (state == ST_STREAM);

    always_comb begin
        peak.pixel = ptr;
        peak.bin   = snap_bin[ptr];
        peak.count = snap_count[ptr];
    end

endmodule

`default_nettype wire

// ==== hist_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_top #(
    parameter int NUM_PIXELS       = 4,
    parameter int HITS_PER_PIXEL   = 2,
    parameter int PASSES_PER_FRAME = 3
) (
    input  wire logic             clk,
    input  wire logic             combin_res,
    input  wire logic             hit_valid,
    input  wire hist_pkg::bin_t   hit_bin,
    output logic                  count_valid,
    output hist_pkg::count_t      bin_count,
    output logic                  frame_done,
    output logic                  bank,
    output logic                  peak_valid,
    output hist_pkg::hist_peak_t  peak
);

    hist_pkg::hist_hit_t    hit;
    hist_pkg::hist_update_t update;

    hist_sequencer #(
        .NUM_PIXELS       (NUM_PIXELS),
        .HITS_PER_PIXEL   (HITS_PER_PIXEL),
        .PASSES_PER_FRAME (PASSES_PER_FRAME)
    ) seq_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .hit        (hit)
    );

    hist_bin_ram #(
        .NUM_PIXELS (NUM_PIXELS)
    ) ram_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .update     (update)
    );

    hist_peak_finder #(
        .NUM_PIXELS (NUM_PIXELS)
    ) peak_i (
        .clk        (clk),
        .combin_res (combin_res),
        .update     (update),
        .peak_valid (peak_valid),
        .peak       (peak)
    );

    assign count_valid = update.valid;
    assign bin_count   = update.count;
    assign frame_done  = update.valid && update.last;

    // flips once per completed frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bank <= 1'b0;
        end else if (frame_done) begin
            bank <= ~bank;
        end
    end

endmodule

`default_nettype wire

// ==== hist_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module hist_assert #(
    parameter int NUM_PIXELS = 4
) (
    input wire logic clk,
    input wire logic combin_res,
    input wire logic hit_valid,
    input wire logic count_valid,
    input wire logic frame_done,
    input wire logic bank,
    input wire logic peak_valid
);

    int peak_run;        // stream cycles still owed
    int fail_count = 0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peak_run <= 0;
        end else if (frame_done) begin
            peak_run <= NUM_PIXELS;
        end else if (peak_run != 0) begin
            peak_run <= peak_run - 1;
        end
    end

    peak_stream_len: assert property (@(posedge clk) disable iff (!combin_res)
        peak_valid == (peak_run != 0))
        else begin
            $error("peak_valid does not span NUM_PIXELS cycles after frame_done");
            fail_count++;
        end

    bank_on_frame: assert property (@(posedge clk) disable iff (!combin_res)
        (bank !== $past(bank)) |-> $past(frame_done))
        else begin
            $error("bank changed without frame_done");
            fail_count++;
        end

    count_latency: assert property (@(posedge clk) disable iff (!combin_res)
        count_valid == $past(hit_valid))
        else begin
            $error("count_valid does not follow hit_valid by one cycle");
            fail_count++;
        end

endmodule

bind hist_top hist_assert #(.NUM_PIXELS(NUM_PIXELS)) assert_i (
    .clk         (clk),
    .combin_res  (combin_res),
    .hit_valid   (hit_valid),
    .count_valid (count_valid),
    .frame_done  (frame_done),
    .bank        (bank),
    .peak_valid  (peak_valid)
);

`default_nettype wire

// ==== tb_hist.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_hist;

    localparam int NUM_PIXELS = 4;

    logic                 clk;
    logic                 combin_res;
    logic                 hit_valid;
    hist_pkg::bin_t       hit_bin;
    logic                 count_valid;
    hist_pkg::count_t     bin_count;
    logic                 frame_done;
    logic                 bank;
    logic                 peak_valid;
    hist_pkg::hist_peak_t peak;

    logic [7:0] rec_kind [$];  // H, P or I
    int         rec_a [$];
    int         rec_b [$];
    int         rec_c [$];

    hist_pkg::count_t     exp_count_q [$];
    logic                 exp_done_q [$];
    hist_pkg::hist_peak_t exp_peak_q [$];

    logic exp_bank;
    logic exp_done;
    int   peak_left;    // peak records still due in the current stream
    int   wait_cycles;  // negedges the oldest hit has waited
    int   cycle_count;
    int   cycle_limit;

    hist_top #(
        .NUM_PIXELS       (NUM_PIXELS),
        .HITS_PER_PIXEL   (2),
        .PASSES_PER_FRAME (3)
    ) dut_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_valid   (hit_valid),
        .hit_bin     (hit_bin),
        .count_valid (count_valid),
        .bin_count   (bin_count),
        .frame_done  (frame_done),
        .bank        (bank),
        .peak_valid  (peak_valid),
        .peak        (peak)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_count(input string name, input hist_pkg::count_t got,
                               input hist_pkg::count_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_peak(input hist_pkg::hist_peak_t got,
                              input hist_pkg::hist_peak_t exp);
        string got_s;
        string exp_s;
        got_s = $sformatf("pixel %0d bin %0d count %0d", got.pixel, got.bin, got.count);
        exp_s = $sformatf("pixel %0d bin %0d count %0d", exp.pixel, exp.bin, exp.count);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: peak got %s expected %s",
                               $time, got_s, exp_s));
        end
    endtask

    // each record is one letter and up to three decimal fields
    task automatic read_stimulus();
        int          fd;
        int          code;
        int          a;
        int          b;
        int          c;
        logic [7:0]  tag;
        logic [1023:0] skip_line;
        fd = $fopen("hist_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open stimulus file hist_stimulus.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            a = 0;
            b = 0;
            c = 0;
            if (tag == "#") begin
                code = $fgets(skip_line, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%d", a);
                if (code != 1) fail_run("malformed idle record in stimulus file");
                rec_kind.push_back(tag);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end else if (tag == "H" || tag == "P") begin
                code = $fscanf(fd, "%d %d %d", a, b, c);
                if (code != 3) fail_run("malformed hit or peak record in stimulus file");
                rec_kind.push_back(tag);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end else begin
                fail_run("unknown record type in stimulus file");
            end
        end
        $fclose(fd);
    endtask

    // stall guard sized from the record count
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (dut_i.assert_i.fail_count != 0) begin
            fail_run("an assertion in the bound checker on hist_top failed");
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (peak_left != 0) begin
            if (!peak_valid) begin
                fail_run("peak record missing from the stream");
            end else if (exp_peak_q.size() == 0) begin
                fail_run("peak record arrived with no expected value");
            end else begin
                check_peak(peak, exp_peak_q.pop_front());
                peak_left = peak_left - 1;
            end
        end else if (peak_valid) begin
            fail_run("unexpected peak strobe outside a stream");
        end

        exp_done = 1'b0;
        if (count_valid) begin
            if (exp_count_q.size() == 0) begin
                fail_run("count strobe with no hit outstanding");
            end else begin
                check_count("bin_count", bin_count, exp_count_q.pop_front());
                exp_done = exp_done_q.pop_front();
                check_flag("frame_done", frame_done, exp_done);
                wait_cycles = 0;
            end
        end else begin
            check_flag("frame_done", frame_done, 1'b0);
            if (exp_count_q.size() != 0) begin
                wait_cycles = wait_cycles + 1;
                if (wait_cycles > 1) fail_run("count strobe missing one cycle after a hit");
            end
        end

        check_flag("bank", bank, exp_bank);
        if (exp_done) begin
            exp_bank  = ~exp_bank;   // flips on the edge that ends frame_done
            peak_left = NUM_PIXELS;  // stream starts next cycle
        end
    end

    initial begin
        hist_pkg::hist_peak_t pk;
        combin_res  = 1'b0;
        hit_valid   = 1'b0;
        hit_bin     = '0;
        exp_bank    = 1'b0;
        exp_done    = 1'b0;
        peak_left   = 0;
        wait_cycles = 0;
        cycle_count = 0;
        cycle_limit = 0;
        read_stimulus();
        cycle_limit = 4 * rec_kind.size() + 100;
        repeat (16) @(posedge clk);
        combin_res <= 1'b1;
        for (int r = 0; r < rec_kind.size(); r++) begin
            if (rec_kind[r] == "H") begin
                @(posedge clk);
                hit_valid <= 1'b1;
                hit_bin   <= hist_pkg::bin_t'(rec_a[r]);
                exp_count_q.push_back(hist_pkg::count_t'(rec_b[r]));
                exp_done_q.push_back(rec_c[r] != 0);
            end else if (rec_kind[r] == "P") begin
                pk.pixel = hist_pkg::pix_t'(rec_a[r]);
                pk.bin   = hist_pkg::bin_t'(rec_b[r]);
                pk.count = hist_pkg::count_t'(rec_c[r]);
                exp_peak_q.push_back(pk);
            end else begin
                repeat (rec_a[r]) begin
                    @(posedge clk);
                    hit_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        hit_valid <= 1'b0;
        while (exp_count_q.size() != 0 || exp_peak_q.size() != 0 || peak_left != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (dut_i.assert_i.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            fail_run("an assertion in the bound checker on hist_top failed");
        end
    end

endmodule

`default_nettype wire

// ==== hist_stimulus.txt ====
# H bin expected_count expected_frame_done | P pixel peak_bin peak_count | I idle_cycles
# all fields decimal, hits go to pixels 0..3 two at a time, three passes per frame
I 2
H 3 1 0
H 3 2 0
H 9 1 0
H 1 1 0
H 7 1 0
H 7 2 0
H 15 1 0
H 4 1 0
I 3
H 5 1 0
H 5 2 0
H 2 1 0
I 1
H 4 1 0
H 7 3 0
H 2 1 0
H 4 2 0
H 15 2 0
H 3 3 0
H 5 3 0
H 6 1 0
H 8 1 0
I 2
H 2 2 0
H 2 3 0
H 4 3 0
H 12 1 1
P 0 3 3
P 1 9 1
P 2 7 3
P 3 4 3
# second frame starts back to back, overlapping the peak stream
H 3 1 0
H 5 1 0
H 9 1 0
H 9 2 0
H 7 1 0
H 10 1 0
H 4 1 0
H 4 2 0
H 3 2 0
H 5 2 0
I 1
H 9 3 0
H 9 4 0
H 11 1 0
H 12 1 0
H 4 3 0
H 15 1 0
H 1 1 0
H 1 2 0
H 9 5 0
I 4
H 9 6 0
H 13 1 0
H 14 1 0
H 15 2 0
H 15 3 1
P 0 3 2
P 1 9 6
P 2 7 1
P 3 4 3
I 4

// ==== Makefile ====
TOP         ?= tb_hist
SEED_DEFINE ?= -DSEED=34294
LOG         ?= sim.log
VERILATOR   ?= verilator
OBJ_DIR     ?= obj_dir
FILELIST    ?= tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator from $(FILELIST), run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP SEED_DEFINE LOG VERILATOR OBJ_DIR FILELIST"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal $(SEED_DEFINE) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb.f ====
hist_pkg.sv
hist_sequencer.sv
hist_bin_ram.sv
hist_peak_finder.sv
hist_top.sv
hist_assert.sv
tb_hist.sv
